/* Bender.yml */
package:
  name: softmax

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/softmax_data_pkg.sv
      - src/softmax_ctrl_pkg.sv
      - src/max_tracker.sv
      - src/exp2_lanes.sv
      - src/denom_accumulator.sv
      - src/recip_divider.sv
      - src/lane_normalizer.sv
      - src/softmax_ctrl.sv
      - src/softmax_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_softmax.sv

/* bench/softmax_golden.txt */
# B strb s0 s1 s2 s3 last : input beat in hex, sent in both passes
# E max sum : expected max_o and sum_o after accumulation
# O strb o0 o1 o2 o3 : expected normalized output beat in hex
# Vector A, maximum grows on every beat
B F 00 FE FF FC 0
B F 02 01 00 FD 0
B F 05 03 EC 04 1
E 05 00020780
O F 003F1 000FC 001F8 0003F
O F 00FC4 007E2 003F1 0007E
O F 07E26 01F89 00000 03F13
# Vector B, partial strobes with large unstrobed scores
B 5 F6 32 F8 64 0
B A 78 F9 7F F7 1
E F9 0001E000
O 5 01111 00000 04444 00000
O A 00000 08888 00000 02222
# Vector C, growth past the sum width and a one LSB exponential
B F 9C 9C 9C 9C 0
B F 00 80 80 80 0
B 1 F0 7F 7F 7F 1
E 00 00010001
O F 00000 00000 00000 00000
O F 0FFFF 00000 00000 00000
O 1 00000 00000 00000 00000

/* bench/tb_softmax.sv */
/*
 * Testbench for the softmax datapath top level
 * Golden-file stimulus, output collector, value checker and wait timeouts
 */
`default_nettype none

`include "softmax_settings.svh"

module tb_softmax;

    localparam int ready_limit   = 64;
    localparam int drain_limit   = 64;
    // Pipeline drain plus divider iterations
    localparam int invert_cycles = 36;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           in_valid;
    logic                           in_ready;
    logic                           in_last;
    softmax_data_pkg::lanes_score_t in_data;
    softmax_data_pkg::strb_t        in_strb;
    logic                           out_valid;
    softmax_data_pkg::lanes_exp_t   out_data;
    softmax_data_pkg::strb_t        out_strb;
    softmax_data_pkg::score_t       max_val;
    softmax_data_pkg::sum_t         sum_val;
    logic                           busy;

    // Records from the golden file
    softmax_data_pkg::strb_t        beat_strb [$];
    softmax_data_pkg::lanes_score_t beat_data [$];
    logic                           beat_last [$];
    int                             vec_beats [$];
    logic [7:0]                     vec_max [$];
    softmax_data_pkg::sum_t         vec_sum [$];
    softmax_data_pkg::strb_t        want_strb [$];
    softmax_data_pkg::lanes_exp_t   want_data [$];

    int checks        = 0;
    int errors        = 0;
    int timeouts      = 0;
    int outputs_seen  = 0;
    int outputs_total = 0;
    bit stalled       = 1'b0;

    softmax_top softmax_top_i (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .in_valid_i  ( in_valid  ),
        .in_ready_o  ( in_ready  ),
        .in_last_i   ( in_last   ),
        .in_data_i   ( in_data   ),
        .in_strb_i   ( in_strb   ),
        .out_valid_o ( out_valid ),
        .out_data_o  ( out_data  ),
        .out_strb_o  ( out_strb  ),
        .max_o       ( max_val   ),
        .sum_o       ( sum_val   ),
        .busy_o      ( busy      )
    );

    always #5 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [67:0] actual,
                               input logic [67:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic load_golden();
        int               fd;
        int               code;
        int               nread;
        int               pending;
        logic [8*8-1:0]   tag;
        logic [8*128-1:0] rest;
        logic [31:0]      f0, f1, f2, f3, f4, f5;
        pending = 0;
        fd = $fopen("bench/softmax_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Error: cannot open the golden file bench/softmax_golden.txt");
        end else begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    nread = $fgets(rest, fd);
                end else if (tag == "B") begin
                    nread = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                    beat_strb.push_back(f0[3:0]);
                    beat_data.push_back({f4[7:0], f3[7:0], f2[7:0], f1[7:0]});
                    beat_last.push_back(f5[0]);
                    pending++;
                end else if (tag == "E") begin
                    nread = $fscanf(fd, "%h %h", f0, f1);
                    vec_max.push_back(f0[7:0]);
                    vec_sum.push_back(f1);
                    vec_beats.push_back(pending);
                    pending = 0;
                end else if (tag == "O") begin
                    nread = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    want_strb.push_back(f0[3:0]);
                    want_data.push_back({f4[16:0], f3[16:0], f2[16:0], f1[16:0]});
                end else begin
                    errors++;
                    $display("Error: unknown record type in the golden file");
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
        outputs_total = want_strb.size();
        if (vec_beats.size() == 0) begin
            errors++;
            $display("Error: the golden file holds no complete vector");
        end
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_data  = '0;
        in_strb  = '0;
    endtask

    // Steps one edge at a time until in_ready matches the level
    task automatic wait_ready(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (!stalled && (in_ready !== level) && (cycles < limit)) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!stalled && (in_ready !== level)) begin
            stalled = 1'b1;
            timeouts++;
            $display("Timeout: in_ready_o did not go %s within %0d cycles",
                     level ? "high" : "low", limit);
        end
    endtask

    task automatic send_beat(input int idx);
        int cycles;
        wait_ready(1'b1, ready_limit, cycles);
        if (!stalled) begin
            in_valid = 1'b1;
            in_data  = beat_data[idx];
            in_strb  = beat_strb[idx];
            in_last  = beat_last[idx];
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic run_vector(input int v, input int base);
        int cycles;
        for (int b = 0; b < vec_beats[v]; b++) begin
            send_beat(base + b);
        end
        drive_idle();
        wait_ready(1'b0, 2, cycles);
        wait_ready(1'b1, ready_limit, cycles);
        if (!stalled) begin
            check_value("in_ready_o low cycles", cycles, invert_cycles);
            check_value("max_o", $unsigned(max_val), vec_max[v]);
            check_value("sum_o", sum_val, vec_sum[v]);
            check_value("busy_o", busy, 1'b1);
        end
        // Second pass over the same beats
        for (int b = 0; b < vec_beats[v]; b++) begin
            send_beat(base + b);
        end
    endtask

    task automatic wait_outputs();
        int cycles;
        cycles = 0;
        while ((outputs_seen < outputs_total) && (cycles < drain_limit)) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (outputs_seen < outputs_total) begin
            timeouts++;
            $display("Timeout: only %0d of %0d output beats arrived",
                     outputs_seen, outputs_total);
        end
    endtask

    // Output beats are compared in arrival order
    initial begin : collector
        softmax_data_pkg::strb_t      strb_exp;
        softmax_data_pkg::lanes_exp_t data_exp;
        forever begin
            @(negedge clk_i);
            if (out_valid === 1'b1) begin
                if (want_strb.size() == 0) begin
                    errors++;
                    $display("Error: output beat arrived with no expected beat left");
                end else begin
                    strb_exp = want_strb.pop_front();
                    data_exp = want_data.pop_front();
                    check_value("out_strb_o", out_strb, strb_exp);
                    for (int i = 0; i < `SOFTMAX_LANES; i++) begin
                        check_value($sformatf("out_data_o[%0d]", i), out_data[i], data_exp[i]);
                    end
                end
                outputs_seen++;
            end
        end
    end

    initial begin
        int base;
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        drive_idle();
        load_golden();
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        check_value("max_o", $unsigned(max_val), 8'h80);
        check_value("sum_o", sum_val, 32'h0);
        check_value("in_ready_o", in_ready, 1'b1);
        check_value("out_valid_o", out_valid, 1'b0);
        check_value("busy_o", busy, 1'b0);

        // Vectors follow each other with no idle cycle
        base = 0;
        for (int v = 0; v < vec_beats.size(); v++) begin
            run_vector(v, base);
            base += vec_beats[v];
        end
        drive_idle();
        wait_outputs();
        repeat (4) @(posedge clk_i);
        #1;
        check_value("output beat count", outputs_seen, outputs_total);
        check_value("busy_o", busy, 1'b0);

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/denom_accumulator.sv */
/*
 * Softmax denominator
 * Lane reduction and rescale-then-add running sum
 */
`default_nettype none

`include "softmax_settings.svh"

module denom_accumulator (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         valid_i,
    input  logic                         acc_en_i,
    input  logic                         first_i,
    input  softmax_data_pkg::lanes_exp_t exp_i,
    input  softmax_data_pkg::strb_t      strb_i,
    input  logic [`SOFTMAX_GROW_W-1:0]   grow_i,
    output softmax_data_pkg::sum_t       sum_o
);

    localparam int unsigned lane_sum_w = `SOFTMAX_FRAC_W + 1 + $clog2(`SOFTMAX_LANES);

    logic [lane_sum_w-1:0]  lane_sum;
    softmax_data_pkg::sum_t scaled;
    softmax_data_pkg::sum_t sum_q;

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            if (strb_i[i]) begin
                lane_sum = lane_sum + lane_sum_w'(exp_i[i]);
            end
        end
    end

    // Old terms were relative to a smaller maximum
    assign scaled = (grow_i >= `SOFTMAX_SUM_SHIFT_MAX) ? '0 : sum_q >> grow_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sum_q <= '0;
        end else if (first_i) begin
            sum_q <= '0;
        end else if (valid_i && acc_en_i) begin
            sum_q <= scaled + softmax_data_pkg::sum_t'(lane_sum);
        end
    end

    assign sum_o = sum_q;

endmodule

`default_nettype wire

/* src/exp2_lanes.sv */
/*
 * Per-lane base-2 exponential relative to the current maximum
 * Saturating shift of 1.0, registered with strobes and growth
 */
`default_nettype none

`include "softmax_settings.svh"

module exp2_lanes (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           valid_i,
    input  softmax_data_pkg::lanes_score_t data_i,
    input  softmax_data_pkg::strb_t        strb_i,
    input  softmax_data_pkg::score_t       max_i,
    input  logic [`SOFTMAX_GROW_W-1:0]     grow_i,
    output softmax_data_pkg::lanes_exp_t   exp_o,
    output softmax_data_pkg::strb_t        strb_o,
    output logic [`SOFTMAX_GROW_W-1:0]     grow_o
);

    localparam softmax_data_pkg::exp_t exp_one = 1 << `SOFTMAX_FRAC_W;

    logic signed [`SOFTMAX_SCORE_W:0] diff [`SOFTMAX_LANES];
    softmax_data_pkg::lanes_exp_t     exp_d;
    softmax_data_pkg::lanes_exp_t     exp_q;
    softmax_data_pkg::strb_t          strb_q;
    logic [`SOFTMAX_GROW_W-1:0]       grow_q;

    always_comb begin
        exp_d = '0;
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            diff[i] = max_i - data_i[i];
            // Beyond 16 halvings the value is below one LSB
            if (strb_i[i] && (diff[i] >= 0) && (diff[i] <= `SOFTMAX_EXP_SHIFT_MAX)) begin
                exp_d[i] = exp_one >> diff[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            strb_q <= '0;
        end else if (valid_i) begin
            strb_q <= strb_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            exp_q  <= exp_d;
            grow_q <= grow_i;
        end
    end

    assign exp_o  = exp_q;
    assign strb_o = strb_q;
    assign grow_o = grow_q;

endmodule

`default_nettype wire

/* src/lane_normalizer.sv */
/*
 * Per-lane multiply of the exponentials by the reciprocal
 * Result truncated by 16 bits into the output register
 */
`default_nettype none

`include "softmax_settings.svh"

module lane_normalizer (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         valid_i,
    input  logic                         norm_en_i,
    input  softmax_data_pkg::lanes_exp_t exp_i,
    input  softmax_data_pkg::strb_t      strb_i,
    input  softmax_data_pkg::recip_t     recip_i,
    output logic                         out_valid_o,
    output softmax_data_pkg::lanes_exp_t out_data_o,
    output softmax_data_pkg::strb_t      out_strb_o
);

    localparam int unsigned prod_w = `SOFTMAX_FRAC_W + 1 + `SOFTMAX_RECIP_W;

    logic [prod_w-1:0]            prod [`SOFTMAX_LANES];
    softmax_data_pkg::lanes_exp_t norm_d;
    softmax_data_pkg::lanes_exp_t data_q;
    softmax_data_pkg::strb_t      strb_q;
    logic                         valid_q;
    logic                         load;

    assign load = valid_i && norm_en_i;

    always_comb begin
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            prod[i]   = exp_i[i] * recip_i;
            norm_d[i] = strb_i[i] ? prod[i][`SOFTMAX_FRAC_W +: `SOFTMAX_FRAC_W+1] : '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            strb_q  <= '0;
        end else begin
            valid_q <= load;
            if (load) begin
                strb_q <= strb_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= norm_d;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;
    assign out_strb_o  = strb_q;

endmodule

`default_nettype wire

/* src/max_tracker.sv */
/*
 * Running maximum over the strobed lanes of each beat
 * Registers beat data, strobes, maximum and growth for the next stage
 */
`default_nettype none

`include "softmax_settings.svh"

module max_tracker (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           valid_i,
    input  logic                           first_i,
    input  logic                           track_en_i,
    input  softmax_data_pkg::lanes_score_t data_i,
    input  softmax_data_pkg::strb_t        strb_i,
    output softmax_data_pkg::lanes_score_t data_o,
    output softmax_data_pkg::strb_t        strb_o,
    output softmax_data_pkg::score_t       max_o,
    output logic [`SOFTMAX_GROW_W-1:0]     grow_o
);

    localparam softmax_data_pkg::score_t score_min = {1'b1, {(`SOFTMAX_SCORE_W-1){1'b0}}};

    softmax_data_pkg::score_t       prev_max;
    softmax_data_pkg::score_t       beat_max;
    softmax_data_pkg::score_t       max_q;
    softmax_data_pkg::lanes_score_t data_q;
    softmax_data_pkg::strb_t        strb_q;
    logic [`SOFTMAX_GROW_W-1:0]     grow_d;
    logic [`SOFTMAX_GROW_W-1:0]     grow_q;

    // A new vector starts from the smallest score
    assign prev_max = first_i ? score_min : max_q;

    always_comb begin
        beat_max = prev_max;
        for (int i = 0; i < `SOFTMAX_LANES; i++) begin
            if (strb_i[i] && (data_i[i] > beat_max)) begin
                beat_max = data_i[i];
            end
        end
    end

    // Never negative, the beat maximum starts at the previous one
    assign grow_d = track_en_i ? beat_max - prev_max : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            max_q <= score_min;
        end else if (track_en_i) begin
            max_q <= beat_max;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_q <= data_i;
            strb_q <= strb_i;
            grow_q <= grow_d;
        end
    end

    assign data_o = data_q;
    assign strb_o = strb_q;
    assign max_o  = max_q;
    assign grow_o = grow_q;

endmodule

`default_nettype wire

/* src/recip_divider.sv */
/*
 * Serial restoring divider for the reciprocal 2^32 / divisor
 * One quotient bit per cycle, done 33 cycles after start
 */
`default_nettype none

`include "softmax_settings.svh"

module recip_divider (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     start_i,
    input  softmax_data_pkg::sum_t   divisor_i,
    output softmax_data_pkg::recip_t recip_o,
    output logic                     done_o
);

    localparam int unsigned steps = `SOFTMAX_SUM_W + 1;
    localparam int unsigned cnt_w = $clog2(steps);

    logic [cnt_w-1:0]         cnt_q;
    logic                     done_q;
    logic                     step;
    softmax_data_pkg::sum_t   divisor;
    softmax_data_pkg::sum_t   divisor_q;
    softmax_data_pkg::sum_t   rem_q;
    logic [`SOFTMAX_SUM_W:0]  rem_shift;
    logic [`SOFTMAX_SUM_W:0]  rem_d;
    logic                     fit;
    softmax_data_pkg::recip_t quot_d;
    softmax_data_pkg::recip_t quot_q;

    assign step    = start_i || (cnt_q != '0);
    assign divisor = start_i ? divisor_i : divisor_q;

    // Only the leading dividend bit is set, every later bit shifts in zero
    assign rem_shift = start_i ? (`SOFTMAX_SUM_W+1)'(1) : {rem_q, 1'b0};
    assign fit       = rem_shift >= {1'b0, divisor};
    assign rem_d     = fit ? rem_shift - {1'b0, divisor} : rem_shift;

    assign quot_d = start_i ? softmax_data_pkg::recip_t'(fit)
                            : {quot_q[`SOFTMAX_RECIP_W-2:0], fit};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= !start_i && (cnt_q == cnt_w'(1));
            if (start_i) begin
                cnt_q <= cnt_w'(steps - 1);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            divisor_q <= divisor_i;
        end
        if (step) begin
            // Remainder stays below the divisor
            rem_q  <= rem_d[`SOFTMAX_SUM_W-1:0];
            quot_q <= quot_d;
        end
    end

    assign recip_o = quot_q;
    assign done_o  = done_q;

endmodule

`default_nettype wire

/* src/softmax_ctrl.sv */
/*
 * Pass controller FSM
 * Input ready, drain counter, divider start and stage valid pipeline
 */
`default_nettype none

module softmax_ctrl (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic in_valid_i,
    input  logic in_last_i,
    input  logic div_done_i,
    output logic in_ready_o,
    output logic first_o,
    output logic track_en_o,
    output logic s1_valid_o,
    output logic s2_valid_o,
    output logic acc_en_o,
    output logic div_start_o,
    output logic norm_en_o,
    output logic busy_o
);

    softmax_ctrl_pkg::pass_state_e state_q;
    softmax_ctrl_pkg::pass_state_e state_d;

    logic [1:0] drain_q;
    logic [1:0] valid_sr_q;
    logic [1:0] acc_sr_q;
    logic       accept;
    logic       accum_pass;

    assign in_ready_o = (state_q != softmax_ctrl_pkg::INVERT);
    assign accept     = in_valid_i && in_ready_o;

    // A beat taken in IDLE opens the accumulation pass
    assign accum_pass = (state_q == softmax_ctrl_pkg::IDLE) ||
                        (state_q == softmax_ctrl_pkg::ACCUM);
    assign first_o    = accept && (state_q == softmax_ctrl_pkg::IDLE);
    assign track_en_o = accept && accum_pass;

    // Start once the last beat has reached the sum
    assign div_start_o = (state_q == softmax_ctrl_pkg::INVERT) && (drain_q == 2'd1);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            softmax_ctrl_pkg::IDLE, softmax_ctrl_pkg::ACCUM: begin
                if (accept) begin
                    state_d = in_last_i ? softmax_ctrl_pkg::INVERT : softmax_ctrl_pkg::ACCUM;
                end
            end
            softmax_ctrl_pkg::INVERT: begin
                if (div_done_i) begin
                    state_d = softmax_ctrl_pkg::NORM;
                end
            end
            softmax_ctrl_pkg::NORM: begin
                if (accept && in_last_i) begin
                    state_d = softmax_ctrl_pkg::IDLE;
                end
            end
            default: state_d = softmax_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= softmax_ctrl_pkg::IDLE;
            drain_q    <= '0;
            valid_sr_q <= '0;
            acc_sr_q   <= '0;
        end else begin
            state_q    <= state_d;
            valid_sr_q <= {valid_sr_q[0], accept};
            acc_sr_q   <= {acc_sr_q[0], track_en_o};
            if (track_en_o && in_last_i) begin
                drain_q <= 2'd3;
            end else if (drain_q != '0) begin
                drain_q <= drain_q - 1'b1;
            end
        end
    end

    assign s1_valid_o = valid_sr_q[0];
    assign s2_valid_o = valid_sr_q[1];
    assign acc_en_o   = acc_sr_q[1];
    assign norm_en_o  = valid_sr_q[1] && !acc_sr_q[1];
    assign busy_o     = (state_q != softmax_ctrl_pkg::IDLE) || (valid_sr_q != '0);

endmodule

`default_nettype wire

/* src/softmax_ctrl_pkg.sv */
/*
 * Control types of the softmax datapath
 * Pass controller states
 */
`default_nettype none

package softmax_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        INVERT,
        NORM
    } pass_state_e;

endpackage

`default_nettype wire

/* src/softmax_data_pkg.sv */
/*
 * Data types of the softmax datapath
 * Scores, exponentials, sums, reciprocals and lane vectors
 */
`default_nettype none

`include "softmax_settings.svh"

package softmax_data_pkg;

    typedef logic signed [`SOFTMAX_SCORE_W-1:0] score_t;

    // Q1.16, 1.0 is 2^16
    typedef logic [`SOFTMAX_FRAC_W:0] exp_t;

    typedef logic [`SOFTMAX_SUM_W-1:0] sum_t;
    typedef logic [`SOFTMAX_RECIP_W-1:0] recip_t;

    typedef score_t [`SOFTMAX_LANES-1:0] lanes_score_t;
    typedef exp_t [`SOFTMAX_LANES-1:0] lanes_exp_t;
    typedef logic [`SOFTMAX_LANES-1:0] strb_t;

endpackage

`default_nettype wire

/* src/softmax_settings.svh */
/*
 * Softmax datapath settings
 * Lane count, data widths and shift limits
 */
`ifndef SOFTMAX_SETTINGS_SVH
`define SOFTMAX_SETTINGS_SVH

// Lanes per input beat
`define SOFTMAX_LANES 4

// Signed log2 score
`define SOFTMAX_SCORE_W 8

// Exponential is Q1.16
`define SOFTMAX_FRAC_W 16

`define SOFTMAX_SUM_W 32
`define SOFTMAX_RECIP_W 17

// Growth of the maximum within one beat, 0 to 255
`define SOFTMAX_GROW_W 8

// Shifts beyond these limits flush the value to zero
`define SOFTMAX_EXP_SHIFT_MAX `SOFTMAX_FRAC_W
`define SOFTMAX_SUM_SHIFT_MAX `SOFTMAX_SUM_W

`endif

/* src/softmax_top.sv */
/*
 * Softmax datapath top level
 * Two-pass flow: max and denominator, reciprocal, normalization
 */
`default_nettype none

`include "softmax_settings.svh"

module softmax_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           in_valid_i,
    output logic                           in_ready_o,
    input  logic                           in_last_i,
    input  softmax_data_pkg::lanes_score_t in_data_i,
    input  softmax_data_pkg::strb_t        in_strb_i,
    output logic                           out_valid_o,
    output softmax_data_pkg::lanes_exp_t   out_data_o,
    output softmax_data_pkg::strb_t        out_strb_o,
    output softmax_data_pkg::score_t       max_o,
    output softmax_data_pkg::sum_t         sum_o,
    output logic                           busy_o
);

    logic first;
    logic track_en;
    logic s1_valid;
    logic s2_valid;
    logic acc_en;
    logic div_start;
    logic div_done;
    logic norm_en;

    softmax_data_pkg::lanes_score_t s1_data;
    softmax_data_pkg::strb_t        s1_strb;
    logic [`SOFTMAX_GROW_W-1:0]     s1_grow;
    softmax_data_pkg::lanes_exp_t   s2_exp;
    softmax_data_pkg::strb_t        s2_strb;
    logic [`SOFTMAX_GROW_W-1:0]     s2_grow;
    softmax_data_pkg::recip_t       recip;

    softmax_ctrl i_ctrl (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .in_valid_i  ( in_valid_i  ),
        .in_last_i   ( in_last_i   ),
        .div_done_i  ( div_done    ),
        .in_ready_o  ( in_ready_o  ),
        .first_o     ( first       ),
        .track_en_o  ( track_en    ),
        .s1_valid_o  ( s1_valid    ),
        .s2_valid_o  ( s2_valid    ),
        .acc_en_o    ( acc_en      ),
        .div_start_o ( div_start   ),
        .norm_en_o   ( norm_en     ),
        .busy_o      ( busy_o      )
    );

    // Payload follows the raw valid, stage valids come from the controller
    max_tracker i_max_tracker (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .valid_i    ( in_valid_i ),
        .first_i    ( first      ),
        .track_en_i ( track_en   ),
        .data_i     ( in_data_i  ),
        .strb_i     ( in_strb_i  ),
        .data_o     ( s1_data    ),
        .strb_o     ( s1_strb    ),
        .max_o      ( max_o      ),
        .grow_o     ( s1_grow    )
    );

    exp2_lanes i_exp2_lanes (
        .clk_i   ( clk_i    ),
        .rst_ni  ( rst_ni   ),
        .valid_i ( s1_valid ),
        .data_i  ( s1_data  ),
        .strb_i  ( s1_strb  ),
        .max_i   ( max_o    ),
        .grow_i  ( s1_grow  ),
        .exp_o   ( s2_exp   ),
        .strb_o  ( s2_strb  ),
        .grow_o  ( s2_grow  )
    );

    denom_accumulator i_denom_accumulator (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .valid_i  ( s2_valid ),
        .acc_en_i ( acc_en   ),
        .first_i  ( first    ),
        .exp_i    ( s2_exp   ),
        .strb_i   ( s2_strb  ),
        .grow_i   ( s2_grow  ),
        .sum_o    ( sum_o    )
    );

    recip_divider i_recip_divider (
        .clk_i     ( clk_i     ),
        .rst_ni    ( rst_ni    ),
        .start_i   ( div_start ),
        .divisor_i ( sum_o     ),
        .recip_o   ( recip     ),
        .done_o    ( div_done  )
    );

    lane_normalizer i_lane_normalizer (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .valid_i     ( s2_valid    ),
        .norm_en_i   ( norm_en     ),
        .exp_i       ( s2_exp      ),
        .strb_i      ( s2_strb     ),
        .recip_i     ( recip       ),
        .out_valid_o ( out_valid_o ),
        .out_data_o  ( out_data_o  ),
        .out_strb_o  ( out_strb_o  )
    );

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/softmax_data_pkg.sv
src/softmax_ctrl_pkg.sv
src/max_tracker.sv
src/exp2_lanes.sv
src/denom_accumulator.sv
src/recip_divider.sv
src/lane_normalizer.sv
src/softmax_ctrl.sv
src/softmax_top.sv
bench/tb_softmax.sv
